//--- game_display_top.sv
`default_nettype none
`include "game_settings.svh"

module game_display_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`GAME_CHOICE_W-1:0] choice1,
    input  logic [`GAME_CHOICE_W-1:0] choice2,
    input  logic [`GAME_DIGIT_W-1:0]  digit_a,
    input  logic [`GAME_DIGIT_W-1:0]  digit_b,
    input  game_pkg::result_e         result,
    output game_pkg::led_rgb_t        led1,
    output game_pkg::led_rgb_t        led2,
    output logic [`GAME_SEG_W-1:0]    seg_data,
    output logic [`GAME_POS_W-1:0]    seg_pos,
    output game_pkg::lcd_bus_t        lcd
);
    import game_pkg::*;

    logic       lcd_req;
    logic       lcd_ack;
    lcd_write_t lcd_wr;
    result_e    rom_msg;
    logic       rom_line;
    logic [3:0] rom_col;
    logic [7:0] rom_char;

    led_indicator led_indicator_i (
        .clk(clk), .rst(rst), .choice1(choice1), .choice2(choice2), .led1(led1), .led2(led2)
    );

    seg_scanner seg_scanner_i (
        .clk(clk), .rst(rst), .digit_a(digit_a), .digit_b(digit_b),
        .seg_data(seg_data), .seg_pos(seg_pos)
    );

    lcd_sequencer lcd_sequencer_i (
        .clk(clk), .rst(rst), .result(result), .req(lcd_req), .ack(lcd_ack), .wr(lcd_wr),
        .msg(rom_msg), .line(rom_line), .col(rom_col), .char(rom_char)
    );

    lcd_message_rom lcd_message_rom_i (
        .msg(rom_msg), .line(rom_line), .col(rom_col), .char(rom_char)
    );

    lcd_bus lcd_bus_i (
        .clk(clk), .rst(rst), .req(lcd_req), .wr(lcd_wr), .ack(lcd_ack), .lcd(lcd)
    );

endmodule

`default_nettype wire

//--- game_pkg.sv
`default_nettype none
`include "game_settings.svh"

package game_pkg;

    typedef enum logic [1:0] {
        RESULT_NONE,
        RESULT_P1,
        RESULT_P2
    } result_e;

    typedef enum logic [2:0] {
        POWERUP,
        FUNC,
        ENTRY,
        DISPLAY,
        LINE1,
        LINE2,
        HOME,
        REFRESH
    } lcd_state_e;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    typedef struct packed {
        logic       rs;
        logic [7:0] data;
    } lcd_write_t;

    typedef struct packed {
        logic       e;
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    // Segment order a..g, MSB is a
    function automatic logic [`GAME_SEG_W-1:0] glyph_of(input logic [`GAME_DIGIT_W-1:0] digit);
        case (digit)
            3'd1:    return 7'h30;
            3'd2:    return 7'h6D;
            3'd3:    return 7'h79;
            3'd4:    return 7'h33;
            3'd5:    return 7'h5B;
            default: return 7'h00; // Blank
        endcase
    endfunction

    function automatic led_rgb_t led_of(input logic [`GAME_CHOICE_W-1:0] choice);
        case (choice)
            2'd1:    return '{r: 1'b1, g: 1'b0, b: 1'b0};
            2'd2:    return '{r: 1'b0, g: 1'b1, b: 1'b0};
            2'd3:    return '{r: 1'b0, g: 1'b0, b: 1'b1};
            default: return '{r: 1'b0, g: 1'b0, b: 1'b0};
        endcase
    endfunction

endpackage

`default_nettype wire

//--- game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Display widths
`define GAME_CHOICE_W 2
`define GAME_DIGIT_W 3
`define GAME_SEG_W 7
`define GAME_POS_W 8
`define GAME_LCD_LINE_CHARS 16

// LCD timing in clock cycles
`define GAME_LCD_POWERUP_CYCLES 70
`define GAME_LCD_CMD_WAIT_CYCLES 30
`define GAME_LCD_REFRESH_CYCLES 400
`define GAME_LCD_SETUP_CYCLES 2
`define GAME_LCD_E_HIGH_CYCLES 4
`define GAME_LCD_HOLD_CYCLES 2

// LCD command bytes
`define GAME_LCD_CMD_FUNCTION 8'h3C
`define GAME_LCD_CMD_ENTRY 8'h06
`define GAME_LCD_CMD_DISPLAY 8'h0C
`define GAME_LCD_CMD_HOME 8'h02
`define GAME_LCD_ADDR_LINE1 8'h80
`define GAME_LCD_ADDR_LINE2 8'hC0

`endif

//--- lcd_bus.sv
`default_nettype none
`include "game_settings.svh"

module lcd_bus (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  game_pkg::lcd_write_t wr,
    output logic                 ack,
    output game_pkg::lcd_bus_t   lcd
);
    import game_pkg::*;

    localparam int TOTAL = `GAME_LCD_SETUP_CYCLES + `GAME_LCD_E_HIGH_CYCLES +
                           `GAME_LCD_HOLD_CYCLES;
    localparam int CNT_W = $clog2(TOTAL);
    localparam logic [CNT_W-1:0] E_RISE = CNT_W'(`GAME_LCD_SETUP_CYCLES - 1);
    localparam logic [CNT_W-1:0] E_FALL =
        CNT_W'(`GAME_LCD_SETUP_CYCLES + `GAME_LCD_E_HIGH_CYCLES - 1);
    localparam logic [CNT_W-1:0] CYCLE_LAST = CNT_W'(TOTAL - 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             e;
    logic             accept;
    lcd_write_t       wr_q;

    assign accept = req && !busy && !ack; // New cycle only after ack is low

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            e    <= 1'b0;
            ack  <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt == E_RISE) e <= 1'b1;
            if (cnt == E_FALL) e <= 1'b0;
            if (cnt == CYCLE_LAST) begin
                busy <= 1'b0;
                ack  <= 1'b1; // Hold time done
            end
        end else if (ack && !req) begin
            ack <= 1'b0;
        end
    end

    // RS and data held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) wr_q <= wr;
    end

    always_comb begin
        lcd = '{e: e, rs: wr_q.rs, rw: 1'b0, data: wr_q.data}; // Write only
    end

endmodule

`default_nettype wire

//--- lcd_message_rom.sv
`default_nettype none

module lcd_message_rom (
    input  game_pkg::result_e msg,
    input  logic              line,
    input  logic [3:0]        col,
    output logic [7:0]        char
);
    import game_pkg::*;

    localparam logic [7:0] SPACE = 8'h20;
    localparam logic [7:0] HEART = 8'h9D;

    logic [7:0] player_char;
    logic [7:0] line1_char;
    logic [7:0] line2_char;

    assign player_char = (msg == RESULT_P1) ? 8'h31 : 8'h32; // '1' or '2'

    // " Px Win"
    always_comb begin
        case (col)
            4'd1:    line1_char = 8'h50;
            4'd2:    line1_char = player_char;
            4'd4:    line1_char = 8'h57;
            4'd5:    line1_char = 8'h69;
            4'd6:    line1_char = 8'h6E;
            default: line1_char = SPACE;
        endcase
    end

    // Two groups of three hearts
    always_comb begin
        case (col)
            4'd1,
            4'd2,
            4'd3,
            4'd5,
            4'd6,
            4'd7:    line2_char = HEART;
            default: line2_char = SPACE;
        endcase
    end

    always_comb begin
        if (msg == RESULT_P1 || msg == RESULT_P2) begin
            char = line ? line2_char : line1_char;
        end else begin
            char = SPACE; // No winner, blank screen
        end
    end

endmodule

`default_nettype wire

//--- lcd_sequencer.sv
`default_nettype none
`include "game_settings.svh"

module lcd_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::result_e    result,
    output logic                 req,
    input  logic                 ack,
    output game_pkg::lcd_write_t wr,
    output game_pkg::result_e    msg,
    output logic                 line,
    output logic [3:0]           col,
    input  logic [7:0]           char
);
    import game_pkg::*;

    localparam int WAIT_W = $clog2(`GAME_LCD_REFRESH_CYCLES);
    localparam logic [WAIT_W-1:0] POWERUP_LAST = WAIT_W'(`GAME_LCD_POWERUP_CYCLES - 1);
    localparam logic [WAIT_W-1:0] CMD_WAIT_LAST = WAIT_W'(`GAME_LCD_CMD_WAIT_CYCLES - 1);
    localparam logic [WAIT_W-1:0] REFRESH_LAST = WAIT_W'(`GAME_LCD_REFRESH_CYCLES - 1);
    localparam logic [3:0] COL_LAST = 4'(`GAME_LCD_LINE_CHARS - 1);

    lcd_state_e        state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              addr_sent; // Line address done, now characters
    logic              wr_sent;   // Ack seen for the current write
    logic              is_write;
    logic              issue;
    logic              wr_done;
    lcd_write_t        next_wr;

    assign is_write = state inside {FUNC, ENTRY, DISPLAY, LINE1, LINE2, HOME};
    assign issue = is_write && !req && !wr_sent && !ack;
    assign wr_done = wr_sent && !ack; // Four-phase cycle closed
    assign line = (state == LINE2);

    always_comb begin
        case (state)
            FUNC:    next_wr = '{rs: 1'b0, data: `GAME_LCD_CMD_FUNCTION};
            ENTRY:   next_wr = '{rs: 1'b0, data: `GAME_LCD_CMD_ENTRY};
            DISPLAY: next_wr = '{rs: 1'b0, data: `GAME_LCD_CMD_DISPLAY};
            LINE1:   next_wr = addr_sent ? lcd_write_t'{rs: 1'b1, data: char} :
                                           lcd_write_t'{rs: 1'b0, data: `GAME_LCD_ADDR_LINE1};
            LINE2:   next_wr = addr_sent ? lcd_write_t'{rs: 1'b1, data: char} :
                                           lcd_write_t'{rs: 1'b0, data: `GAME_LCD_ADDR_LINE2};
            HOME:    next_wr = '{rs: 1'b0, data: `GAME_LCD_CMD_HOME};
            default: next_wr = '{rs: 1'b0, data: 8'h00};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= POWERUP;
            wait_cnt  <= '0;
            addr_sent <= 1'b0;
            wr_sent   <= 1'b0;
            col       <= '0;
            req       <= 1'b0;
            msg       <= RESULT_NONE;
        end else begin
            if (req && ack) begin
                req     <= 1'b0;
                wr_sent <= 1'b1;
            end else if (issue) begin
                req <= 1'b1;
                wr  <= next_wr;
            end

            case (state)
                POWERUP: begin
                    if (wait_cnt == POWERUP_LAST) begin
                        wait_cnt <= '0;
                        state    <= FUNC;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                FUNC, ENTRY, DISPLAY: begin
                    if (wr_done) begin
                        if (wait_cnt == CMD_WAIT_LAST) begin
                            wait_cnt <= '0;
                            wr_sent  <= 1'b0;
                            state    <= lcd_state_e'(state + 1'b1); // Next init step
                            if (state == DISPLAY) msg <= result; // First frame
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                LINE1, LINE2: begin
                    if (wr_done) begin
                        wr_sent <= 1'b0;
                        if (!addr_sent) begin
                            addr_sent <= 1'b1;
                        end else if (col == COL_LAST) begin
                            col       <= '0;
                            addr_sent <= 1'b0;
                            state     <= (state == LINE1) ? LINE2 : HOME;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                HOME: begin
                    if (wr_done) begin
                        wr_sent <= 1'b0;
                        state   <= REFRESH;
                    end
                end
                default: begin
                    if (wait_cnt == REFRESH_LAST) begin
                        wait_cnt <= '0;
                        msg      <= result; // Latched once per frame
                        state    <= LINE1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- led_indicator.sv
`default_nettype none
`include "game_settings.svh"

module led_indicator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`GAME_CHOICE_W-1:0] choice1,
    input  logic [`GAME_CHOICE_W-1:0] choice2,
    output game_pkg::led_rgb_t        led1,
    output game_pkg::led_rgb_t        led2
);
    import game_pkg::*;

    logic p1_active;
    logic p2_active;
    logic single_active;

    assign p1_active = (choice1 != '0);
    assign p2_active = (choice2 != '0);
    assign single_active = p1_active ^ p2_active; // Exactly one player

    always_ff @(posedge clk) begin
        if (!rst) begin
            led1 <= '0;
            led2 <= '0;
        end else if (single_active) begin
            led1 <= led_of(choice1); // Idle player decodes to dark
            led2 <= led_of(choice2);
        end
    end

    // Ties and double idle keep the last shown colours

endmodule

`default_nettype wire

//--- seg_scanner.sv
`default_nettype none
`include "game_settings.svh"

module seg_scanner (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`GAME_DIGIT_W-1:0] digit_a,
    input  logic [`GAME_DIGIT_W-1:0] digit_b,
    output logic [`GAME_SEG_W-1:0]   seg_data,
    output logic [`GAME_POS_W-1:0]   seg_pos
);
    import game_pkg::*;

    logic [1:0]             phase;
    logic [`GAME_SEG_W-1:0] glyph_a;
    logic [`GAME_SEG_W-1:0] glyph_b;

    // Glyph decode stage
    always_ff @(posedge clk) begin
        if (!rst) begin
            glyph_a <= '0;
            glyph_b <= '0;
        end else begin
            glyph_a <= glyph_of(digit_a);
            glyph_b <= glyph_of(digit_b);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase    <= '0;
            seg_pos  <= '0;
            seg_data <= '0;
        end else begin
            phase <= phase + 1'b1; // Free running
            case (phase)
                2'd0: begin
                    seg_pos  <= 8'h01;
                    seg_data <= glyph_a;
                end
                2'd1: begin
                    seg_pos  <= 8'h80;
                    seg_data <= glyph_b;
                end
                default: begin
                    seg_pos  <= '0;
                    seg_data <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb_game_display.sv
`default_nettype none
`include "game_settings.svh"

module tb_game_display;
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    localparam int LINE_CHARS = `GAME_LCD_LINE_CHARS;
    localparam int FRAME_WRITES = 2 * LINE_CHARS + 3;
    localparam int LCD_TIMEOUT = 3000; // Clocks, well above one frame

    logic                      clk = 1'b0;
    logic                      rst;
    logic [`GAME_CHOICE_W-1:0] choice1;
    logic [`GAME_CHOICE_W-1:0] choice2;
    logic [`GAME_DIGIT_W-1:0]  digit_a;
    logic [`GAME_DIGIT_W-1:0]  digit_b;
    result_e                   result;
    led_rgb_t                  led1;
    led_rgb_t                  led2;
    logic [`GAME_SEG_W-1:0]    seg_data;
    logic [`GAME_POS_W-1:0]    seg_pos;
    lcd_bus_t                  lcd;
    logic                      lcd_e;

    logic [8:0] lcd_q[$]; // Captured {rs, data}
    int         n_checks = 0;
    int         n_errors = 0;
    int         mon_writes = 0;
    int         mon_errors = 0;

    game_display_top game_display_top_i (
        .clk(clk), .rst(rst), .choice1(choice1), .choice2(choice2),
        .digit_a(digit_a), .digit_b(digit_b), .result(result),
        .led1(led1), .led2(led2), .seg_data(seg_data), .seg_pos(seg_pos), .lcd(lcd)
    );

    assign lcd_e = lcd.e;

    always #10 clk = ~clk;

    function automatic logic [2:0] ref_led(input logic [1:0] choice);
        case (choice)
            2'd1:    return 3'b100; // Red
            2'd2:    return 3'b010; // Green
            2'd3:    return 3'b001; // Blue
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [6:0] ref_glyph(input logic [2:0] digit);
        case (digit)
            3'd1:    return 7'h30;
            3'd2:    return 7'h6D;
            3'd3:    return 7'h79;
            3'd4:    return 7'h33;
            3'd5:    return 7'h5B;
            default: return 7'h00;
        endcase
    endfunction

    // Entry idx of the expected frame
    function automatic logic [8:0] ref_lcd_frame(input result_e res, input int idx);
        string      text;
        int         col;
        logic [7:0] ch;
        text = (res == RESULT_P1) ? " P1 Win" : " P2 Win";
        if (idx == 0) return {1'b0, `GAME_LCD_ADDR_LINE1};
        if (idx == LINE_CHARS + 1) return {1'b0, `GAME_LCD_ADDR_LINE2};
        if (idx == FRAME_WRITES - 1) return {1'b0, `GAME_LCD_CMD_HOME};
        if (res != RESULT_P1 && res != RESULT_P2) return {1'b1, 8'h20};
        if (idx <= LINE_CHARS) begin
            col = idx - 1;
            ch = (col < text.len()) ? text[col] : 8'h20;
            return {1'b1, ch};
        end
        col = idx - LINE_CHARS - 2;
        ch = (col % 4 != 0 && col < 8) ? 8'h9D : 8'h20; // Hearts in cols 1 to 3 and 5 to 7
        return {1'b1, ch};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("Timeout: %s did not arrive in time", what);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic wait_lcd_writes(input int count);
        int cycles;
        cycles = 0;
        while (lcd_q.size() < count && cycles < LCD_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (lcd_q.size() < count) report_timeout($sformatf("%0d LCD writes", count));
    endtask

    // Drops writes up to and including the next return-home
    task automatic skip_to_frame_end;
        int         cycles;
        logic       found;
        logic [8:0] w;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < LCD_TIMEOUT) begin
            if (lcd_q.size() > 0) begin
                w = lcd_q.pop_front();
                if (w == {1'b0, `GAME_LCD_CMD_HOME}) found = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!found) report_timeout("end of LCD frame");
    endtask

    initial begin : lcd_monitor
        logic [8:0] at_rise;
        int         errs;
        forever begin
            @(posedge lcd_e);
            errs = n_errors;
            check("lcd.rw", lcd.rw, 1'b0);
            at_rise = {lcd.rs, lcd.data};
            @(negedge lcd_e);
            check("lcd.data", {lcd.rs, lcd.data}, at_rise); // Held over the enable pulse
            lcd_q.push_back({lcd.rs, lcd.data});
            mon_writes++;
            mon_errors += n_errors - errs;
        end
    end

    initial begin : stimulus
        int         errs;
        int         cycles;
        logic [2:0] exp_led1;
        logic [2:0] exp_led2;
        logic [7:0] exp_pos;
        logic [6:0] exp_seg;
        result_e    res_list[3];

        void'($urandom(69325));
        res_list = '{RESULT_P1, RESULT_P2, RESULT_NONE};
        rst = 1'b0;
        choice1 = '0;
        choice2 = '0;
        digit_a = '0;
        digit_b = '0;
        result = RESULT_NONE;
        repeat (4) @(posedge clk);
        @(negedge clk);

        errs = n_errors;
        check("led1", led1, 3'b000);
        check("led2", led2, 3'b000);
        check("seg_data", seg_data, 7'h00);
        check("seg_pos", seg_pos, 8'h00);
        check("lcd.e", lcd.e, 1'b0);
        report_test("reset values", errs);
        rst = 1'b1;

        errs = n_errors;
        exp_led1 = '0;
        exp_led2 = '0;
        for (int i = 0; i < 50; i++) begin
            choice1 = 2'($urandom_range(3));
            choice2 = 2'($urandom_range(3));
            if ((choice1 != 0) != (choice2 != 0)) begin
                exp_led1 = ref_led(choice1);
                exp_led2 = ref_led(choice2);
            end
            @(negedge clk);
            check("led1", led1, exp_led1);
            check("led2", led2, exp_led2);
        end
        report_test("led decode", errs);

        errs = n_errors;
        for (int p = 0; p < 6; p++) begin
            digit_a = 3'($urandom_range(7));
            digit_b = 3'($urandom_range(7));
            repeat (2) @(negedge clk);
            cycles = 0;
            while (seg_pos !== 8'h01 && cycles < 8) begin
                @(negedge clk);
                cycles++;
            end
            if (seg_pos !== 8'h01) begin
                report_timeout("digit A slot of the scanner");
            end else begin
                for (int k = 0; k < 8; k++) begin
                    exp_pos = (k % 4 == 0) ? 8'h01 : (k % 4 == 1) ? 8'h80 : 8'h00;
                    exp_seg = (k % 4 == 0) ? ref_glyph(digit_a) :
                              (k % 4 == 1) ? ref_glyph(digit_b) : 7'h00;
                    check("seg_pos", seg_pos, exp_pos);
                    check("seg_data", seg_data, exp_seg);
                    @(negedge clk);
                end
            end
        end
        report_test("seven segment scan", errs);

        errs = n_errors;
        wait_lcd_writes(3);
        if (lcd_q.size() >= 3) begin
            check("lcd write 0", lcd_q[0], {1'b0, `GAME_LCD_CMD_FUNCTION});
            check("lcd write 1", lcd_q[1], {1'b0, `GAME_LCD_CMD_ENTRY});
            check("lcd write 2", lcd_q[2], {1'b0, `GAME_LCD_CMD_DISPLAY});
        end
        report_test("lcd init", errs);

        foreach (res_list[r]) begin
            errs = n_errors;
            @(negedge clk);
            result = res_list[r];
            lcd_q.delete();
            skip_to_frame_end(); // Frame in flight may carry the old result
            wait_lcd_writes(FRAME_WRITES);
            if (lcd_q.size() >= FRAME_WRITES) begin
                for (int i = 0; i < FRAME_WRITES; i++) begin
                    check($sformatf("lcd write %0d", i), lcd_q[i],
                          ref_lcd_frame(res_list[r], i));
                end
            end
            report_test($sformatf("lcd frame %s", res_list[r].name()), errs);
        end

        if (mon_writes == 0) begin
            n_errors++;
            $display("No LCD write was seen on the bus");
        end
        $display("lcd bus monitor: %0d writes, %0d errors", mon_writes, mon_errors);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
game_pkg.sv
led_indicator.sv
seg_scanner.sv
lcd_message_rom.sv
lcd_bus.sv
lcd_sequencer.sv
game_display_top.sv
tb_game_display.sv
